/* rtl/core_pkg.sv */
package core_pkg;

  // machine widths
  localparam int XLEN            = 32;
  localparam int ARCH_ADDR_WIDTH = 5;
  localparam int ARCH_REGS       = 1 << ARCH_ADDR_WIDTH;

  // ROB geometry, a tag is {row, bank}
  localparam int DISPATCH_WIDTH  = 2;
  localparam int ROB_SIZE        = 8;
  localparam int ROB_ADDR_WIDTH  = 3;
  localparam int BANK_WIDTH      = 1;
  localparam int TAG_WIDTH       = ROB_ADDR_WIDTH + BANK_WIDTH;
  localparam int NUM_SRC_PORTS   = 2 * DISPATCH_WIDTH;
  localparam int MUL_LATENCY     = 3;

  // internal ALU operation codes
  localparam int OP_WIDTH = 4;
  localparam logic [OP_WIDTH-1:0] OP_ADD = 4'd0;
  localparam logic [OP_WIDTH-1:0] OP_SUB = 4'd1;
  localparam logic [OP_WIDTH-1:0] OP_AND = 4'd2;
  localparam logic [OP_WIDTH-1:0] OP_OR  = 4'd3;
  localparam logic [OP_WIDTH-1:0] OP_XOR = 4'd4;
  localparam logic [OP_WIDTH-1:0] OP_SLT = 4'd5;
  localparam logic [OP_WIDTH-1:0] OP_SLL = 4'd6;
  localparam logic [OP_WIDTH-1:0] OP_SRL = 4'd7;
  localparam logic [OP_WIDTH-1:0] OP_MUL = 4'd8;

endpackage

/* rtl/isa_pkg.sv */
package isa_pkg;

  // major opcodes, register and immediate ALU forms
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLL = 3'b001;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_SRL = 3'b101;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_SUB    = 7'b0100000;
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  // one instruction word, R-type or I-type view
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
  } instr_t;

endpackage

/* rtl/rob_ifs.sv */
`timescale 1ns/100ps

// pair allocation into the ROB head row
interface rob_dispatch_if import core_pkg::*; ();
  logic [DISPATCH_WIDTH-1:0]  en;
  logic [ARCH_ADDR_WIDTH-1:0] arch_rd [DISPATCH_WIDTH];
  logic                       full;
  logic [ROB_ADDR_WIDTH-1:0]  rob_addr;

  modport decode (output en, arch_rd, input full, rob_addr);
  modport rob (input en, arch_rd, output full, rob_addr);
endinterface

// source lookup, answered combinationally
interface rob_op_fetch_if import core_pkg::*; ();
  logic [ARCH_ADDR_WIDTH-1:0] arch_rs1 [DISPATCH_WIDTH];
  logic [ARCH_ADDR_WIDTH-1:0] arch_rs2 [DISPATCH_WIDTH];
  logic [DISPATCH_WIDTH-1:0]  rs1_hit;
  logic [DISPATCH_WIDTH-1:0]  rs1_ready;
  logic [TAG_WIDTH-1:0]       rs1_tag [DISPATCH_WIDTH];
  logic [DISPATCH_WIDTH-1:0]  rs2_hit;
  logic [DISPATCH_WIDTH-1:0]  rs2_ready;
  logic [TAG_WIDTH-1:0]       rs2_tag [DISPATCH_WIDTH];

  modport decode (output arch_rs1, arch_rs2,
                  input rs1_hit, rs1_ready, rs1_tag, rs2_hit, rs2_ready, rs2_tag);
  modport rob (input arch_rs1, arch_rs2,
               output rs1_hit, rs1_ready, rs1_tag, rs2_hit, rs2_ready, rs2_tag);
endinterface

// one writeback port per execute lane
interface rob_wb_if import core_pkg::*; ();
  logic [DISPATCH_WIDTH-1:0] en;
  logic [ROB_ADDR_WIDTH-1:0] rob_addr [DISPATCH_WIDTH];
  logic [BANK_WIDTH-1:0]     bank [DISPATCH_WIDTH];
  logic [XLEN-1:0]           data [DISPATCH_WIDTH];

  modport execute (output en, rob_addr, bank, data);
  modport rob (input en, rob_addr, bank);
  modport result (input en, rob_addr, bank, data);
endinterface

// in-order retirement of the tail row
interface rob_commit_if import core_pkg::*; ();
  logic [DISPATCH_WIDTH-1:0]  en;
  logic [ARCH_ADDR_WIDTH-1:0] arch_rd [DISPATCH_WIDTH];
  logic [ROB_ADDR_WIDTH-1:0]  rob_addr [DISPATCH_WIDTH];
  logic [BANK_WIDTH-1:0]      bank [DISPATCH_WIDTH];

  modport rob (output en, arch_rd, rob_addr, bank);
  modport result (input en, arch_rd, rob_addr, bank);
endinterface

interface exec_issue_if import core_pkg::*; ();
  logic [DISPATCH_WIDTH-1:0] valid;
  logic [OP_WIDTH-1:0]       op [DISPATCH_WIDTH];
  logic [XLEN-1:0]           a [DISPATCH_WIDTH];
  logic [XLEN-1:0]           b [DISPATCH_WIDTH];
  logic [ROB_ADDR_WIDTH-1:0] rob_addr [DISPATCH_WIDTH];
  logic [BANK_WIDTH-1:0]     bank [DISPATCH_WIDTH];
  logic [DISPATCH_WIDTH-1:0] lane_ready;

  modport decode (output valid, op, a, b, rob_addr, bank, input lane_ready);
  modport execute (input valid, op, a, b, rob_addr, bank, output lane_ready);
endinterface

/* rtl/rename_decode.sv */
`timescale 1ns/100ps

module rename_decode import core_pkg::*, isa_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [DISPATCH_WIDTH-1:0]  in_valid,
  input  instr_t                     in_instr [DISPATCH_WIDTH],
  output logic                       in_ready,
  rob_dispatch_if.decode             dispatch,
  rob_op_fetch_if.decode             op_fetch,
  exec_issue_if.decode               issue,
  output logic [TAG_WIDTH-1:0]       rd_tag [NUM_SRC_PORTS],
  output logic [NUM_SRC_PORTS-1:0]   rd_from_buf,
  output logic [ARCH_ADDR_WIDTH-1:0] rd_arch [NUM_SRC_PORTS],
  input  logic [XLEN-1:0]            rd_value [NUM_SRC_PORTS]
);

  // held pair, one bit per lane still waiting to issue
  logic [DISPATCH_WIDTH-1:0]  pending;
  logic [OP_WIDTH-1:0]        op_q [DISPATCH_WIDTH];
  logic [DISPATCH_WIDTH-1:0]  use_imm_q;
  logic [XLEN-1:0]            imm_q [DISPATCH_WIDTH];
  logic [ARCH_ADDR_WIDTH-1:0] rs1_q [DISPATCH_WIDTH];
  logic [ARCH_ADDR_WIDTH-1:0] rs2_q [DISPATCH_WIDTH];
  logic [ROB_ADDR_WIDTH-1:0]  row_q;
  logic [DISPATCH_WIDTH-1:0]  src_ok;
  logic                       accept;

  function automatic logic [OP_WIDTH-1:0] f3_op(input logic [2:0] f3);
    case (f3)
      F3_ADD:  return OP_ADD;
      F3_SLL:  return OP_SLL;
      F3_SLT:  return OP_SLT;
      F3_XOR:  return OP_XOR;
      F3_SRL:  return OP_SRL;
      F3_OR:   return OP_OR;
      F3_AND:  return OP_AND;
      default: return OP_ADD;
    endcase
  endfunction

  // immediate forms read funct3 from the i view, register forms use funct7 too
  function automatic logic [OP_WIDTH-1:0] decode_op(input instr_t ins);
    logic [OP_WIDTH-1:0] op;
    op = f3_op(ins.i.funct3);
    if (ins.r.opcode == OPC_OP) begin
      case (ins.r.funct7)
        F7_MULDIV: op = OP_MUL;
        F7_SUB:    op = (ins.r.funct3 == F3_ADD) ? OP_SUB : op;
        F7_BASE:   op = f3_op(ins.r.funct3);
        default:   op = OP_ADD;
      endcase
    end
    return op;
  endfunction

  assign in_ready = !dispatch.full && !(|pending);
  assign accept   = in_ready && (|in_valid);
  assign dispatch.en = in_valid & {DISPATCH_WIDTH{in_ready}};

  always_comb begin
    for (int w = 0; w < DISPATCH_WIDTH; w++) begin
      dispatch.arch_rd[w] = in_instr[w].r.rd;

      op_fetch.arch_rs1[w] = rs1_q[w];
      op_fetch.arch_rs2[w] = use_imm_q[w] ? '0 : rs2_q[w];

      // value path, ROB buffer on a hit, architectural file otherwise
      rd_tag[2*w]        = op_fetch.rs1_tag[w];
      rd_from_buf[2*w]   = op_fetch.rs1_hit[w];
      rd_arch[2*w]       = op_fetch.arch_rs1[w];
      rd_tag[2*w+1]      = op_fetch.rs2_tag[w];
      rd_from_buf[2*w+1] = op_fetch.rs2_hit[w];
      rd_arch[2*w+1]     = op_fetch.arch_rs2[w];

      src_ok[w] = (!op_fetch.rs1_hit[w] || op_fetch.rs1_ready[w]) &&
                  (!op_fetch.rs2_hit[w] || op_fetch.rs2_ready[w]);

      // lanes go out independently, so bank 1 can wait on bank 0
      issue.valid[w]    = pending[w] && src_ok[w] && issue.lane_ready[w];
      issue.op[w]       = op_q[w];
      issue.a[w]        = rd_value[2*w];
      issue.b[w]        = use_imm_q[w] ? imm_q[w] : rd_value[2*w+1];
      issue.rob_addr[w] = row_q;
      issue.bank[w]     = BANK_WIDTH'(w);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
    end else if (accept) begin
      pending <= in_valid;
    end else begin
      pending <= pending & ~issue.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      row_q <= dispatch.rob_addr;
      for (int w = 0; w < DISPATCH_WIDTH; w++) begin
        op_q[w]      <= decode_op(in_instr[w]);
        use_imm_q[w] <= in_instr[w].i.opcode == OPC_OP_IMM;
        imm_q[w]     <= XLEN'($signed(in_instr[w].i.imm));
        rs1_q[w]     <= in_instr[w].r.rs1;
        rs2_q[w]     <= in_instr[w].r.rs2;
      end
    end
  end

endmodule

/* rtl/rob.sv */
`timescale 1ns/100ps

module rob import core_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  rob_dispatch_if.rob dispatch,
  rob_op_fetch_if.rob op_fetch,
  rob_wb_if.rob       wb,
  rob_commit_if.rob   commit
);

  logic [DISPATCH_WIDTH-1:0]  entry_valid [ROB_SIZE];
  logic [DISPATCH_WIDTH-1:0]  entry_ready [ROB_SIZE];
  logic [ARCH_ADDR_WIDTH-1:0] entry_rd [ROB_SIZE][DISPATCH_WIDTH];

  // head is the next row to allocate, tail the next row to retire
  logic [ROB_ADDR_WIDTH-1:0] head;
  logic [ROB_ADDR_WIDTH-1:0] tail;
  logic [ROB_ADDR_WIDTH:0]   count;
  logic                      dispatch_any;
  logic                      tail_commit;

  // ----------------------------------------
  // source search
  // ----------------------------------------
  // the newest row is the pair being renamed; there only lower banks count.
  // rows are walked oldest first so the youngest match is kept
  function automatic logic [TAG_WIDTH+1:0] search(input logic [ARCH_ADDR_WIDTH-1:0] src,
                                                  input int bank);
    logic [TAG_WIDTH+1:0]      res;
    logic [ROB_ADDR_WIDTH-1:0] row;
    res = '0;
    for (int k = ROB_SIZE - 1; k >= 0; k--) begin
      row = head - ROB_ADDR_WIDTH'(k + 1);
      for (int w = 0; w < DISPATCH_WIDTH; w++) begin
        if (entry_valid[row][w] && entry_rd[row][w] == src && src != '0 &&
            (k != 0 || w < bank)) begin
          res = {1'b1, entry_ready[row][w], row, BANK_WIDTH'(w)};
        end
      end
    end
    return res;
  endfunction

  always_comb begin
    for (int w = 0; w < DISPATCH_WIDTH; w++) begin
      {op_fetch.rs1_hit[w], op_fetch.rs1_ready[w], op_fetch.rs1_tag[w]} =
        search(op_fetch.arch_rs1[w], w);
      {op_fetch.rs2_hit[w], op_fetch.rs2_ready[w], op_fetch.rs2_tag[w]} =
        search(op_fetch.arch_rs2[w], w);
    end
  end

  // ----------------------------------------
  // dispatch and commit control
  // ----------------------------------------
  assign dispatch_any      = |dispatch.en;
  assign dispatch.full     = count == (ROB_ADDR_WIDTH+1)'(ROB_SIZE);
  assign dispatch.rob_addr = head;

  // at least one valid slot and no valid slot still waiting
  assign tail_commit = (|entry_valid[tail]) &&
                       ((entry_valid[tail] & ~entry_ready[tail]) == '0);

  always_comb begin
    for (int w = 0; w < DISPATCH_WIDTH; w++) begin
      commit.en[w]       = tail_commit && entry_valid[tail][w];
      commit.arch_rd[w]  = entry_rd[tail][w];
      commit.rob_addr[w] = tail;
      commit.bank[w]     = BANK_WIDTH'(w);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      for (int i = 0; i < ROB_SIZE; i++) begin
        entry_valid[i] <= '0;
        entry_ready[i] <= '0;
      end
    end else begin
      if (dispatch_any) begin
        entry_valid[head] <= dispatch.en;
        entry_ready[head] <= '0;
        head <= head + 1'b1;
      end
      for (int w = 0; w < DISPATCH_WIDTH; w++) begin
        if (wb.en[w]) begin
          entry_ready[wb.rob_addr[w]][wb.bank[w]] <= 1'b1;
        end
      end
      if (tail_commit) begin
        entry_valid[tail] <= '0;
        entry_ready[tail] <= '0;
        tail <= tail + 1'b1;
      end
      count <= count + (ROB_ADDR_WIDTH+1)'(dispatch_any) - (ROB_ADDR_WIDTH+1)'(tail_commit);
    end
  end

  // destination names, no reset needed
  always_ff @(posedge clk) begin
    for (int w = 0; w < DISPATCH_WIDTH; w++) begin
      if (dispatch.en[w]) begin
        entry_rd[head][w] <= dispatch.arch_rd[w];
      end
    end
  end

endmodule

/* rtl/alu_execute.sv */
`timescale 1ns/100ps

module alu_execute import core_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  exec_issue_if.execute issue,
  rob_wb_if.execute     wb
);

  function automatic logic [XLEN-1:0] alu_calc(input logic [OP_WIDTH-1:0] op,
                                               input logic [XLEN-1:0] a,
                                               input logic [XLEN-1:0] b);
    case (op)
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SLT:  return XLEN'($signed(a) < $signed(b));
      OP_SLL:  return a << b[$clog2(XLEN)-1:0];
      OP_SRL:  return a >> b[$clog2(XLEN)-1:0];
      default: return a + b;
    endcase
  endfunction

  for (genvar l = 0; l < DISPATCH_WIDTH; l++) begin : g_lane
    logic                      fire_alu;
    logic                      fire_mul;
    logic                      alu_v;
    logic [ROB_ADDR_WIDTH-1:0] alu_addr;
    logic [BANK_WIDTH-1:0]     alu_bank;
    logic [XLEN-1:0]           alu_res;
    logic [MUL_LATENCY-1:0]    mul_v;
    logic [ROB_ADDR_WIDTH-1:0] mul_addr [MUL_LATENCY];
    logic [BANK_WIDTH-1:0]     mul_bank [MUL_LATENCY];
    logic [XLEN-1:0]           mul_a;
    logic [XLEN-1:0]           mul_b;
    logic [XLEN-1:0]           pp_lo;
    logic [XLEN-1:0]           pp_hi;
    logic [XLEN-1:0]           mul_p;

    // an ALU op issued now would finish together with the MUL in stage 1
    assign issue.lane_ready[l] = !(mul_v[MUL_LATENCY-2] && issue.op[l] != OP_MUL);
    assign fire_alu = issue.valid[l] && issue.op[l] != OP_MUL;
    assign fire_mul = issue.valid[l] && issue.op[l] == OP_MUL;

    always_ff @(posedge clk) begin
      if (rst) begin
        alu_v <= 1'b0;
        mul_v <= '0;
      end else begin
        alu_v <= fire_alu;
        mul_v <= {mul_v[MUL_LATENCY-2:0], fire_mul};
      end
    end

    always_ff @(posedge clk) begin
      alu_res     <= alu_calc(issue.op[l], issue.a[l], issue.b[l]);
      alu_addr    <= issue.rob_addr[l];
      alu_bank    <= issue.bank[l];
      mul_addr[0] <= issue.rob_addr[l];
      mul_bank[0] <= issue.bank[l];
      for (int s = 1; s < MUL_LATENCY; s++) begin
        mul_addr[s] <= mul_addr[s-1];
        mul_bank[s] <= mul_bank[s-1];
      end
      // operands, then two half-width partial products, then the sum
      mul_a <= issue.a[l];
      mul_b <= issue.b[l];
      pp_lo <= mul_a * XLEN'(mul_b[XLEN/2-1:0]);
      pp_hi <= mul_a * XLEN'(mul_b[XLEN-1:XLEN/2]);
      mul_p <= pp_lo + (pp_hi << (XLEN/2));
    end

    assign wb.en[l]       = alu_v | mul_v[MUL_LATENCY-1];
    assign wb.data[l]     = mul_v[MUL_LATENCY-1] ? mul_p : alu_res;
    assign wb.rob_addr[l] = mul_v[MUL_LATENCY-1] ? mul_addr[MUL_LATENCY-1] : alu_addr;
    assign wb.bank[l]     = mul_v[MUL_LATENCY-1] ? mul_bank[MUL_LATENCY-1] : alu_bank;
  end

endmodule

/* rtl/result_store.sv */
`timescale 1ns/100ps

module result_store import core_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  rob_wb_if.result                   wb,
  rob_commit_if.result               commit,
  input  logic [TAG_WIDTH-1:0]       rd_tag [NUM_SRC_PORTS],
  input  logic [NUM_SRC_PORTS-1:0]   rd_from_buf,
  input  logic [ARCH_ADDR_WIDTH-1:0] rd_arch [NUM_SRC_PORTS],
  output logic [XLEN-1:0]            rd_value [NUM_SRC_PORTS],
  output logic [DISPATCH_WIDTH-1:0]  commit_valid,
  output logic [ARCH_ADDR_WIDTH-1:0] commit_rd [DISPATCH_WIDTH],
  output logic [XLEN-1:0]            commit_data [DISPATCH_WIDTH]
);

  // in-flight values, indexed by tag
  logic [XLEN-1:0] res_buf [ROB_SIZE*DISPATCH_WIDTH];
  logic [XLEN-1:0] arch_reg [ARCH_REGS];
  logic [XLEN-1:0] commit_val [DISPATCH_WIDTH];

  always_comb begin
    for (int k = 0; k < NUM_SRC_PORTS; k++) begin
      rd_value[k] = rd_from_buf[k] ? res_buf[rd_tag[k]] : arch_reg[rd_arch[k]];
    end
    // x0 reads back as zero even when an instruction targets it
    for (int w = 0; w < DISPATCH_WIDTH; w++) begin
      commit_val[w] = (commit.arch_rd[w] == '0) ? '0 :
                      res_buf[{commit.rob_addr[w], commit.bank[w]}];
    end
  end

  always_ff @(posedge clk) begin
    for (int w = 0; w < DISPATCH_WIDTH; w++) begin
      if (wb.en[w]) begin
        res_buf[{wb.rob_addr[w], wb.bank[w]}] <= wb.data[w];
      end
    end
  end

  // bank 1 is written last, so it wins on a shared rd
  always_ff @(posedge clk) begin
    if (rst) begin
      commit_valid <= '0;
      for (int r = 0; r < ARCH_REGS; r++) begin
        arch_reg[r] <= '0;
      end
    end else begin
      commit_valid <= commit.en;
      for (int w = 0; w < DISPATCH_WIDTH; w++) begin
        if (commit.en[w] && commit.arch_rd[w] != '0) begin
          arch_reg[commit.arch_rd[w]] <= commit_val[w];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int w = 0; w < DISPATCH_WIDTH; w++) begin
      commit_rd[w]   <= commit.arch_rd[w];
      commit_data[w] <= commit_val[w];
    end
  end

endmodule

/* rtl/ooo_core.sv */
`timescale 1ns/100ps

module ooo_core import core_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [DISPATCH_WIDTH-1:0]  in_valid,
  input  logic [XLEN-1:0]            in_instr [DISPATCH_WIDTH],
  output logic                       in_ready,
  output logic [DISPATCH_WIDTH-1:0]  commit_valid,
  output logic [ARCH_ADDR_WIDTH-1:0] commit_rd [DISPATCH_WIDTH],
  output logic [XLEN-1:0]            commit_data [DISPATCH_WIDTH]
);

  rob_dispatch_if dispatch_bus ();
  rob_op_fetch_if op_fetch_bus ();
  rob_wb_if       wb_bus ();
  rob_commit_if   commit_bus ();
  exec_issue_if   issue_bus ();

  // operand reads from decode into the result store
  logic [TAG_WIDTH-1:0]       rd_tag [NUM_SRC_PORTS];
  logic [NUM_SRC_PORTS-1:0]   rd_from_buf;
  logic [ARCH_ADDR_WIDTH-1:0] rd_arch [NUM_SRC_PORTS];
  logic [XLEN-1:0]            rd_value [NUM_SRC_PORTS];

  rename_decode u_rename_decode (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_instr    (in_instr),
    .in_ready    (in_ready),
    .dispatch    (dispatch_bus),
    .op_fetch    (op_fetch_bus),
    .issue       (issue_bus),
    .rd_tag      (rd_tag),
    .rd_from_buf (rd_from_buf),
    .rd_arch     (rd_arch),
    .rd_value    (rd_value)
  );

  rob u_rob (
    .clk      (clk),
    .rst      (rst),
    .dispatch (dispatch_bus),
    .op_fetch (op_fetch_bus),
    .wb       (wb_bus),
    .commit   (commit_bus)
  );

  alu_execute u_alu_execute (
    .clk   (clk),
    .rst   (rst),
    .issue (issue_bus),
    .wb    (wb_bus)
  );

  result_store u_result_store (
    .clk          (clk),
    .rst          (rst),
    .wb           (wb_bus),
    .commit       (commit_bus),
    .rd_tag       (rd_tag),
    .rd_from_buf  (rd_from_buf),
    .rd_arch      (rd_arch),
    .rd_value     (rd_value),
    .commit_valid (commit_valid),
    .commit_rd    (commit_rd),
    .commit_data  (commit_data)
  );

endmodule

/* verif/tb_ooo_core.sv */
`timescale 1ns/100ps

module tb_ooo_core import core_pkg::*; ();

  logic                       clk;
  logic                       rst;
  logic [DISPATCH_WIDTH-1:0]  in_valid;
  logic [XLEN-1:0]            in_instr [DISPATCH_WIDTH];
  logic                       in_ready;
  logic [DISPATCH_WIDTH-1:0]  commit_valid;
  logic [ARCH_ADDR_WIDTH-1:0] commit_rd [DISPATCH_WIDTH];
  logic [XLEN-1:0]            commit_data [DISPATCH_WIDTH];

  // cases file contents
  string           test_name [$];
  int              test_pairs [$];
  int              test_exps [$];
  logic [1:0]      pair_valid [$];
  logic [XLEN-1:0] pair_instr0 [$];
  logic [XLEN-1:0] pair_instr1 [$];
  logic [4:0]      exp_rd [$];
  logic [XLEN-1:0] exp_val [$];

  // commits still expected by the monitor
  logic [4:0]      pend_rd [$];
  logic [XLEN-1:0] pend_val [$];

  integer seed = 32'hd762_1fb9;
  int     errors = 0;
  int     checks = 0;
  int     total_pairs = 0;
  logic   loaded = 1'b0;

  ooo_core u_ooo_core (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .in_instr     (in_instr),
    .in_ready     (in_ready),
    .commit_valid (commit_valid),
    .commit_rd    (commit_rd),
    .commit_data  (commit_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check(input string what, input logic [XLEN-1:0] got,
                       input logic [XLEN-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // ----------------------------------------
  // cases file reader
  // ----------------------------------------
  task automatic load_cases();
    int              fd;
    int              code;
    int              v0;
    int              v1;
    int              rd;
    string           line;
    string           kw;
    string           name;
    logic [XLEN-1:0] i0;
    logic [XLEN-1:0] i1;
    logic [XLEN-1:0] val;
    fd = $fopen("verif/ooo_cases.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the cases file verif/ooo_cases.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        code = $fgets(line, fd);
        kw = "";
        code = $sscanf(line, "%s", kw);
        if (code < 1 || kw.len() == 0 || kw.getc(0) == "#") begin
          continue;
        end
        if (kw == "test") begin
          code = $sscanf(line, "%s %s", kw, name);
          test_name.push_back(name);
          test_pairs.push_back(0);
          test_exps.push_back(0);
        end else if (kw == "pair") begin
          code = $sscanf(line, "%s %d %h %d %h", kw, v0, i0, v1, i1);
          pair_valid.push_back({v1[0], v0[0]});
          pair_instr0.push_back(i0);
          pair_instr1.push_back(i1);
          test_pairs[test_pairs.size()-1]++;
          total_pairs++;
        end else if (kw == "exp") begin
          code = $sscanf(line, "%s %d %h", kw, rd, val);
          exp_rd.push_back(rd[4:0]);
          exp_val.push_back(val);
          test_exps[test_exps.size()-1]++;
        end
      end
      $fclose(fd);
    end
  endtask

  // one pair held on the input until the core takes it
  task automatic send_pair(input logic [1:0] v, input logic [XLEN-1:0] i0,
                           input logic [XLEN-1:0] i1);
    int gap;
    gap = $random(seed) & 3;
    repeat (gap) @(negedge clk);
    @(negedge clk);
    in_valid    = v;
    in_instr[0] = i0;
    in_instr[1] = i1;
    while (!in_ready) begin
      @(negedge clk);
    end
    @(negedge clk);
    // the accepted pair sits in decode until a later edge
    check("in_ready while a pair is held", XLEN'(in_ready), XLEN'(1'b0));
    in_valid = '0;
  endtask

  // commit monitor
  // slot 0 is older than slot 1
  always @(negedge clk) begin
    if (!rst) begin
      for (int w = 0; w < DISPATCH_WIDTH; w++) begin
        if (commit_valid[w]) begin
          if (pend_rd.size() == 0) begin
            errors++;
            $display("extra commit at %0t: x%0d = %h was not expected",
                     $time, commit_rd[w], commit_data[w]);
          end else begin
            check($sformatf("commit rd slot %0d", w), XLEN'(commit_rd[w]),
                  XLEN'(pend_rd.pop_front()));
            check($sformatf("commit data slot %0d", w), commit_data[w],
                  pend_val.pop_front());
          end
        end
      end
    end
  end

  initial begin : watchdog
    wait (loaded);
    repeat (total_pairs * 40 + 20) @(posedge clk);
    $display("timeout, %0d expected commits never arrived", pend_rd.size());
    $display("TESTS FAILED");
    $finish;
  end

  initial begin : main
    int pi;
    int ei;
    int err_before;
    rst         = 1'b1;
    in_valid    = '0;
    in_instr[0] = '0;
    in_instr[1] = '0;
    pi = 0;
    ei = 0;
    load_cases();
    loaded = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check("in_ready after reset", XLEN'(in_ready), XLEN'(1'b1));
    check("commit_valid after reset", XLEN'(commit_valid), XLEN'(0));

    for (int t = 0; t < test_name.size(); t++) begin
      err_before = errors;
      for (int k = 0; k < test_exps[t]; k++) begin
        pend_rd.push_back(exp_rd[ei]);
        pend_val.push_back(exp_val[ei]);
        ei++;
      end
      for (int k = 0; k < test_pairs[t]; k++) begin
        send_pair(pair_valid[pi], pair_instr0[pi], pair_instr1[pi]);
        pi++;
      end
      while (pend_rd.size() != 0) begin
        @(negedge clk);
      end
      // quiet window catches extra commits
      repeat (10) @(negedge clk);
      $display("test %s: %0d commits, %0d errors", test_name[t], test_exps[t],
               errors - err_before);
    end

    $display("summary: %0d tests, %0d checks, %0d errors", test_name.size(), checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* verif/ooo_cases.txt */
# test <name> | pair <valid0> <instr0 hex> <valid1> <instr1 hex>
# exp <rd decimal> <value hex>, in commit order, bank 0 before bank 1
test alu_basic
pair 1 00500093 1 00300113
pair 1 002081B3 1 40208233
pair 1 0020F2B3 1 0020E333
pair 1 0020C3B3 1 00112433
pair 1 002094B3 1 0020D533
pair 1 0FF0C593 1 FFF17613
exp 1 00000005
exp 2 00000003
exp 3 00000008
exp 4 00000002
exp 5 00000001
exp 6 00000007
exp 7 00000006
exp 8 00000001
exp 9 00000028
exp 10 00000000
exp 11 000000FA
exp 12 00000003
test deps
pair 1 00700093 1 00108133
pair 1 00108093 1 00208093
pair 1 000081B3 1 40200233
exp 1 00000007
exp 2 0000000E
exp 1 00000008
exp 1 0000000A
exp 3 0000000A
exp 4 FFFFFFF2
test mul_ooo
pair 1 00600093 1 FFD00113
pair 1 022081B3 1 00108233
pair 1 00900293 1 02210333
exp 1 00000006
exp 2 FFFFFFFD
exp 3 FFFFFFEE
exp 4 0000000C
exp 5 00000009
exp 6 00000009
test mul_chain
pair 1 00300093 1 00100113
pair 1 02110133 1 02110133
pair 1 02110133 1 02110133
pair 1 02110133 1 02110133
pair 1 02110133 1 02110133
pair 1 02110133 1 02110133
pair 1 02110133 1 02110133
exp 1 00000003
exp 2 00000001
exp 2 00000003
exp 2 00000009
exp 2 0000001B
exp 2 00000051
exp 2 000000F3
exp 2 000002D9
exp 2 0000088B
exp 2 000019A1
exp 2 00004CE3
exp 2 0000E6A9
exp 2 0002B3FB
exp 2 00081BF1
test single_x0
pair 0 00000000 1 02A00393
pair 1 00500013 1 00000433
exp 7 0000002A
exp 0 00000000
exp 8 00000000

/* build.f */
rtl/core_pkg.sv
rtl/isa_pkg.sv
rtl/rob_ifs.sv
rtl/rename_decode.sv
rtl/rob.sv
rtl/alu_execute.sv
rtl/result_store.sv
rtl/ooo_core.sv
verif/tb_ooo_core.sv

/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module tb_ooo_core

sim:
	verilator --binary -f build.f --top-module tb_ooo_core -o tb_ooo_core
	./obj_dir/tb_ooo_core | tee sim.log
	@if grep -q "TESTS FAILED" sim.log; then exit 1; fi
	@grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
